// File: pad_defines.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Size limits of the horizontal padding stage
// Include wherever lane counts or data widths are needed
// The guard makes repeated includes harmless
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef PAD_DEFINES_SVH
`define PAD_DEFINES_SVH

// Number of tap lanes and the widest supported kernel
`define KERNEL_W_MAX 7

// Half of the widest kernel, depth of the column shift state
`define KW2_MAX 3

// Width of a kernel width field
`define BITS_KW 3

// Column and cin counter widths
`define COLS_MAX_BITS 6
`define CIN_MAX_BITS 4

// Datapath widths, products are signed two's complement
`define PROD_W 16
`define SUM_W 24

`endif

// File: conv_cfg_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Row configuration and side-band types
// Shared by the column tracker, the pad filter and the top
// Import with a wildcard in the module header
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "pad_defines.svh"

package conv_cfg_pkg;

    // Configuration of one image row, held stable while the row runs
    typedef struct packed {
        logic [`BITS_KW-1:0]       kw;        // Odd kernel width, 1 for a 1x1 row
        logic [`COLS_MAX_BITS-1:0] cols_1;    // Columns in the row minus one
        logic [`CIN_MAX_BITS-1:0]  cin_1;     // Input channels per column minus one
        logic                      is_1x1;    // Pass every lane straight through
    } row_cfg_t;

    // Side-band bits that travel with each beat
    typedef struct packed {
        logic [`BITS_KW-1:0] kw;           // Kernel width of the beat's row
        logic                is_cols_1_k2; // Column is cols_1 - kw/2
        logic                is_acc_last;  // Last cin of the column
        logic                is_1x1;       // Row is a 1x1 convolution
        logic                is_config;    // Beat carries config, lane 0 only
    } pad_user_t;

    // One bit per tap lane
    typedef logic [`KERNEL_W_MAX-1:0] lane_mask_t;

endpackage

// File: lane_data_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Lane product and column sum types
// Used by the masker and the top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "pad_defines.svh"

package lane_data_pkg;

    // One signed product per tap lane
    typedef logic [`KERNEL_W_MAX-1:0][`PROD_W-1:0] lane_prod_t;

    // One accumulator per tap lane
    typedef logic [`KERNEL_W_MAX-1:0][`SUM_W-1:0] lane_sum_t;

    // Result emitted once per column, or once per config beat
    typedef struct packed {
        logic [`SUM_W-1:0] full_sum;   // Sum over the fully formed lanes
        lane_sum_t         part_sums;  // Partial lanes, zero where masked off
        logic              is_config;  // Lane 0 of a config beat in full_sum
    } col_out_t;

endpackage

// File: register.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Clock-enabled register for any payload type
// Set T to the payload and RESET_VALUE to its value after reset
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module register #(
    parameter type T           = logic,
    parameter T    RESET_VALUE = T'(0)
) (
    input  logic aclk,
    input  logic rst_n,
    input  logic clken,   // Load enable, the register holds while low
    input  T     d,
    output T     q
);

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            q <= RESET_VALUE;  // Asynchronous return to the reset value
        end else if (clken) begin
            q <= d;
        end
    end

endmodule

// File: col_tracker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Column tracker for one image row
// Counts cins and columns and builds the per-beat user word
// Pulse row_start with the row's cfg before or with its first beat
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "pad_defines.svh"

module col_tracker
    import conv_cfg_pkg::*;
(
    input  logic      aclk,
    input  logic      rst_n,
    input  logic      aclken,      // Global stall, low freezes the counters
    input  logic      row_start,   // Loads cfg and restarts the counters
    input  logic      valid_in,
    input  logic      cfg_beat,    // Current beat is a config beat
    input  row_cfg_t  cfg,
    output pad_user_t user,
    output logic      user_valid
);

    row_cfg_t                  cfg_r;    // Config latched for the running row
    row_cfg_t                  cfg_act;  // Config that applies to this beat
    logic [`CIN_MAX_BITS-1:0]  cin_cnt;
    logic [`COLS_MAX_BITS-1:0] col_cnt;
    logic [`CIN_MAX_BITS-1:0]  cin_cur;  // Counter values seen by this beat
    logic [`COLS_MAX_BITS-1:0] col_cur;
    logic [`COLS_MAX_BITS:0]   col_k2;   // Column plus kw/2, one bit wider
    logic                      last_cin;
    logic                      last_col;
    logic                      data_acc; // Accepted data beat

    // A beat that arrives with row_start already belongs to the new row
    assign cfg_act = row_start ? cfg : cfg_r;
    assign cin_cur = row_start ? '0 : cin_cnt;
    assign col_cur = row_start ? '0 : col_cnt;

    assign last_cin = (cin_cur == cfg_act.cin_1);
    assign last_col = (col_cur == cfg_act.cols_1);

    // Compare col + kw/2 with cols_1 so no negative value appears
    assign col_k2 = {1'b0, col_cur} + (`COLS_MAX_BITS+1)'(cfg_act.kw >> 1);

    assign data_acc = valid_in && aclken && !cfg_beat;  // Config beats leave counters alone

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            cfg_r   <= '0;
            cin_cnt <= '0;
            col_cnt <= '0;
        end else if (aclken) begin
            if (row_start) begin
                cfg_r <= cfg;            // Held until the next row_start
            end
            if (data_acc) begin
                if (last_cin) begin
                    cin_cnt <= '0;       // Column done, move to the next one
                    col_cnt <= last_col ? '0 : col_cur + 1'b1;
                end else begin
                    cin_cnt <= cin_cur + 1'b1;
                    col_cnt <= col_cur;
                end
            end else if (row_start) begin
                cin_cnt <= '0;           // Row start without a beat
                col_cnt <= '0;
            end
        end
    end

    // Side-band of the beat now on the inputs
    always_comb begin
        user.kw           = cfg_act.kw;
        user.is_1x1       = cfg_act.is_1x1;
        user.is_config    = cfg_beat;
        user.is_acc_last  = last_cin && !cfg_beat;  // Config beats never close a column
        user.is_cols_1_k2 = (col_k2 == {1'b0, cfg_act.cols_1}) && !cfg_beat;
    end

    assign user_valid = valid_in;  // Acceptance is qualified by aclken downstream

endmodule

// File: pad_filter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Horizontal padding mask generator
// Tracks the first and last columns of a row in two shift registers
// and looks up the full and partial lane masks for the beat's kernel
// Every odd kernel up to KERNEL_W_MAX has its own lookup, so kw may
// change from one row to the next without idle cycles
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "pad_defines.svh"

module pad_filter
    import conv_cfg_pkg::*;
(
    input  logic       aclk,
    input  logic       rst_n,
    input  logic       aclken,
    input  logic       valid_in,
    input  pad_user_t  user,
    output lane_mask_t mask_full,
    output lane_mask_t mask_partial
);

    // Bits 1..KW2_MAX, so kw/2 indexes the state without a subtract
    typedef logic [`KW2_MAX:1] col_state_t;

    logic [`BITS_KW-2:0] kw2;         // kw/2, 0 for a 1x1 row
    col_state_t          col_end;     // One-hot position from cols_1 - kw/2 on
    col_state_t          col_start;   // Set while the column is below kw/2
    col_state_t          col_end_d;
    col_state_t          col_start_d;
    logic [`KW2_MAX:0]   end_ext;     // End chain with the incoming bit at index 0
    logic                last_col;    // Beat is in the last column of its row
    logic                shift_en;    // Column closes on this beat

    logic [`KW2_MAX:0] lut_full [`KERNEL_W_MAX];          // Lookup per lane and kw/2
    logic [`KW2_MAX:0] lut_part [1:`KERNEL_W_MAX-1];

    assign kw2 = user.kw[`BITS_KW-1:1];

    assign end_ext  = {col_end, user.is_cols_1_k2};
    assign last_col = end_ext[kw2];  // For kw/2 of 0 the incoming flag is the last column

    assign shift_en = valid_in && aclken && user.is_acc_last;

    // The last column clears the end chain and seeds the start chain for the next row
    assign col_end_d   = last_col ? '0 : end_ext[`KW2_MAX-1:0];
    assign col_start_d = last_col ? col_state_t'(1) : (col_start << 1);

    register #(
        .T           (col_state_t),
        .RESET_VALUE ('0)
    ) col_end_reg (
        .aclk  (aclk),
        .rst_n (rst_n),
        .clken (shift_en),
        .d     (col_end_d),
        .q     (col_end)
    );

    register #(
        .T           (col_state_t),
        .RESET_VALUE ({`KW2_MAX{1'b1}})  // First row starts inside the left border
    ) col_start_reg (
        .aclk  (aclk),
        .rst_n (rst_n),
        .clken (shift_en),
        .d     (col_start_d),
        .q     (col_start)
    );

    // Full mask, the outermost lane of the kernel once past the left border,
    // and lanes kw/2 to kw-1 in the last column where the row is cut short
    for (genvar i = 0; i < `KERNEL_W_MAX; i++) begin : g_full_lane
        assign lut_full[i][0] = 1'b0;  // kw of 1 only passes through is_1x1
        for (genvar k = 1; k <= `KW2_MAX; k++) begin : g_kw2
            logic mid_ok;
            logic end_ok;
            assign mid_ok = (i == 2*k) && !(|col_start[k:1]);        // Left border is over
            assign end_ok = (i >= k) && (i <= 2*k) && col_end[k];    // Last column of the row
            assign lut_full[i][k] = mid_ok || end_ok;
        end
        assign mask_full[i] = user.is_1x1 || lut_full[i][kw2];  // 1x1 passes every lane
    end

    assign mask_partial[0] = 1'b0;  // Lane 0 never holds a partial sum

    // Partial mask, lanes at or below kw/2 stop one column earlier per step
    // down, lanes above kw/2 stop only in the last column
    for (genvar i = 1; i < `KERNEL_W_MAX; i++) begin : g_part_lane
        assign lut_part[i][0] = 1'b0;
        for (genvar k = 1; k <= `KW2_MAX; k++) begin : g_kw2
            if (i > 2*k) begin : g_unused
                assign lut_part[i][k] = 1'b0;                 // Beyond the kernel
            end else if (i > k) begin : g_right
                assign lut_part[i][k] = !col_end[k];
            end else begin : g_left
                assign lut_part[i][k] = !(|col_end[k:i]);     // Triangle of blocked columns
            end
        end
        assign mask_partial[i] = lut_part[i][kw2];
    end

endmodule

// File: psum_masker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Masked lane accumulator
// Adds the unmasked lane products over the cins of a column and
// emits one col_out a cycle after the column's last cin
// Config beats bypass the sums and emit lane 0 alone
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "pad_defines.svh"

module psum_masker
    import conv_cfg_pkg::*;
    import lane_data_pkg::*;
(
    input  logic       aclk,
    input  logic       rst_n,
    input  logic       aclken,
    input  logic       valid_in,
    input  pad_user_t  user,
    input  lane_mask_t mask_full,
    input  lane_mask_t mask_partial,
    input  lane_prod_t prod_in,
    output logic       out_valid,
    output col_out_t   col_out
);

    logic              accept;    // Beat taken this cycle
    logic              emit;      // Beat produces a col_out
    lane_sum_t         acc_q;     // Running sums of the open column
    lane_sum_t         acc_sum;   // Sums including this beat
    lane_sum_t         acc_d;
    lane_sum_t         part_sums;
    logic [`SUM_W-1:0] full_sum;
    logic [`SUM_W-1:0] cfg_sum;   // Lane 0 sign extended

    assign accept = valid_in && aclken;
    assign emit   = accept && (user.is_acc_last || user.is_config);

    always_comb begin
        full_sum = '0;
        for (int i = 0; i < `KERNEL_W_MAX; i++) begin
            acc_sum[i] = acc_q[i];
            if (mask_full[i] || mask_partial[i]) begin
                acc_sum[i] = acc_q[i] +
                    {{(`SUM_W-`PROD_W){prod_in[i][`PROD_W-1]}}, prod_in[i]};
            end
            part_sums[i] = mask_partial[i] ? acc_sum[i] : '0;
            if (mask_full[i]) begin
                full_sum = full_sum + acc_sum[i];  // Full lanes collapse into one sum
            end
        end
    end

    assign acc_d   = user.is_acc_last ? '0 : acc_sum;  // Clear for the next column
    assign cfg_sum = {{(`SUM_W-`PROD_W){prod_in[0][`PROD_W-1]}}, prod_in[0]};

    register #(
        .T           (lane_sum_t),
        .RESET_VALUE ('0)
    ) acc_reg (
        .aclk  (aclk),
        .rst_n (rst_n),
        .clken (accept && !user.is_config),  // Config beats leave the sums alone
        .d     (acc_d),
        .q     (acc_q)
    );

    // Pulse lasts one cycle, also across a stall
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= emit;
        end
    end

    always_ff @(posedge aclk) begin
        if (emit) begin
            if (user.is_config) begin
                col_out.full_sum  <= cfg_sum;
                col_out.part_sums <= '0;
                col_out.is_config <= 1'b1;
            end else begin
                col_out.full_sum  <= full_sum;
                col_out.part_sums <= part_sums;
                col_out.is_config <= 1'b0;
            end
        end
    end

endmodule

// File: pad_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Horizontal zero-padding stage of the accumulator
// Tracker builds the side-band, filter turns it into lane masks,
// masker sums the masked lanes per column
// A beat is taken when valid_in and aclken are both high
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module pad_top
    import conv_cfg_pkg::*;
    import lane_data_pkg::*;
(
    input  logic       aclk,
    input  logic       rst_n,
    input  logic       aclken,      // Global stall
    input  row_cfg_t   cfg,
    input  logic       row_start,   // One-beat pulse that loads cfg
    input  logic       valid_in,
    input  logic       cfg_beat,
    input  lane_prod_t prod_in,
    output logic       out_valid,
    output col_out_t   col_out
);

    pad_user_t  user;          // Side-band of the current beat
    logic       user_valid;
    lane_mask_t mask_full;
    lane_mask_t mask_partial;

    col_tracker u_col_tracker (
        .aclk       (aclk),
        .rst_n      (rst_n),
        .aclken     (aclken),
        .row_start  (row_start),
        .valid_in   (valid_in),
        .cfg_beat   (cfg_beat),
        .cfg        (cfg),
        .user       (user),
        .user_valid (user_valid)
    );

    pad_filter u_pad_filter (
        .aclk         (aclk),
        .rst_n        (rst_n),
        .aclken       (aclken),
        .valid_in     (user_valid),
        .user         (user),
        .mask_full    (mask_full),
        .mask_partial (mask_partial)
    );

    psum_masker u_psum_masker (
        .aclk         (aclk),
        .rst_n        (rst_n),
        .aclken       (aclken),
        .valid_in     (user_valid),
        .user         (user),
        .mask_full    (mask_full),
        .mask_partial (mask_partial),
        .prod_in      (prod_in),
        .out_valid    (out_valid),
        .col_out      (col_out)
    );

endmodule

// File: tb_pad_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Self-checking testbench for the padding stage
// Rows from a table are streamed through the DUT and every col_out
// is compared with a reference built from the lane mask rules
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "pad_defines.svh"

module tb_pad_top
    import conv_cfg_pkg::*;
    import lane_data_pkg::*;
();

    localparam int NUM_ROWS = 9;

    // One row of stimulus
    typedef struct packed {
        logic [`BITS_KW-1:0]       kw;
        logic [`COLS_MAX_BITS-1:0] cols_1;
        logic [`CIN_MAX_BITS-1:0]  cin_1;
        logic                      is_1x1;
        logic                      stall;    // Random aclken gaps inside the row
        logic                      pre_cfg;  // A config beat goes first
    } row_entry_t;

    logic       aclk;
    logic       rst_n;
    logic       aclken;
    logic       row_start;
    logic       valid_in;
    logic       cfg_beat;
    row_cfg_t   cfg;
    lane_prod_t prod_in;
    logic       out_valid;
    col_out_t   col_out;

    row_entry_t  row_table [NUM_ROWS];
    string       row_name [NUM_ROWS];
    col_out_t    exp_q [$];    // Expected results in arrival order
    string       name_q [$];   // Test name and column of each expected result
    logic [31:0] lfsr_state;
    int          errors;
    int          checks;
    logic        table_ready;
    realtime     watchdog_ns;
    col_out_t    exp_val;
    string       exp_name;

    pad_top UUT (
        .aclk      (aclk),
        .rst_n     (rst_n),
        .aclken    (aclken),
        .cfg       (cfg),
        .row_start (row_start),
        .valid_in  (valid_in),
        .cfg_beat  (cfg_beat),
        .prod_in   (prod_in),
        .out_valid (out_valid),
        .col_out   (col_out)
    );

    always #2 aclk = ~aclk;  // 4 ns period

    // Galois LFSR stepped once per bit handed out
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] r;
        logic        b;
        r = '0;
        for (int k = 0; k < n; k++) begin
            b = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (b) begin
                lfsr_state = lfsr_state ^ 32'h80200003;
            end
            r = {r[30:0], b};
        end
        return r;
    endfunction

    function automatic lane_prod_t random_prod();
        lane_prod_t  p;
        logic [31:0] t;
        for (int i = 0; i < `KERNEL_W_MAX; i++) begin
            t = lfsr_bits(`PROD_W);
            p[i] = t[`PROD_W-1:0];
        end
        return p;
    endfunction

    // Products are signed, so sums grow with the sign bit
    function automatic logic [`SUM_W-1:0] sign_extend(input logic [`PROD_W-1:0] p);
        return {{(`SUM_W-`PROD_W){p[`PROD_W-1]}}, p};
    endfunction

    // Applies the full and partial lane rules to the raw lane sums of column c
    function automatic col_out_t expect_column(input row_entry_t r, input int c,
                                               input lane_sum_t sums);
        col_out_t o;
        int       kw;
        int       kw2;
        int       cols;
        logic     full;
        logic     part;
        kw   = int'(r.kw);
        kw2  = kw / 2;
        cols = int'(r.cols_1);
        o    = '0;
        for (int i = 0; i < `KERNEL_W_MAX; i++) begin
            full = ((i == kw - 1) && (c >= kw2)) ||
                   ((c == cols) && (i >= kw2) && (i <= kw - 1)) || r.is_1x1;
            if (i <= kw2) begin
                part = (i >= 1) && (c < cols - (kw2 - i));  // Left lanes stop early
            end else begin
                part = (i <= kw - 1) && (c != cols);        // Right lanes stop at the end
            end
            if (full) begin
                o.full_sum = o.full_sum + sums[i];
            end
            if (part) begin
                o.part_sums[i] = sums[i];
            end
        end
        return o;
    endfunction

    task automatic add_row(input int idx, input string name, input int kw, input int cols_1,
                           input int cin_1, input logic is_1x1, input logic stall,
                           input logic pre_cfg);
        row_table[idx].kw      = kw[`BITS_KW-1:0];
        row_table[idx].cols_1  = cols_1[`COLS_MAX_BITS-1:0];
        row_table[idx].cin_1   = cin_1[`CIN_MAX_BITS-1:0];
        row_table[idx].is_1x1  = is_1x1;
        row_table[idx].stall   = stall;
        row_table[idx].pre_cfg = pre_cfg;
        row_name[idx]          = name;
    endtask

    // Holds one beat on the inputs until a rising edge with aclken high takes it
    task automatic apply_beat(input logic is_cfg, input logic rs, input logic stall_en,
                              input lane_prod_t prod);
        int span;
        span = 0;
        if (stall_en && (lfsr_bits(2) == 0)) begin
            span = 1 + int'(lfsr_bits(1));  // Gap of one or two cycles
        end
        valid_in  = 1'b1;
        cfg_beat  = is_cfg;
        row_start = rs;
        prod_in   = prod;
        repeat (span) begin
            aclken = 1'b0;
            @(posedge aclk);
            #0.5;
        end
        aclken = 1'b1;
        @(posedge aclk);
        #0.5;
    endtask

    task automatic run_row(input int idx);
        row_entry_t r;
        lane_prod_t p;
        lane_sum_t  sums;
        col_out_t   cfg_exp;
        r = row_table[idx];
        cfg.kw     = r.kw;
        cfg.cols_1 = r.cols_1;
        cfg.cin_1  = r.cin_1;
        cfg.is_1x1 = r.is_1x1;
        if (r.pre_cfg) begin
            p = random_prod();
            // Row opens on the config beat and its first data beat must still see cin 0
            apply_beat(1'b1, 1'b1, r.stall, p);
            cfg_exp           = '0;
            cfg_exp.full_sum  = sign_extend(p[0]);  // Only lane 0 of a config beat survives
            cfg_exp.is_config = 1'b1;
            exp_q.push_back(cfg_exp);
            name_q.push_back($sformatf("%s config", row_name[idx]));
        end
        for (int c = 0; c <= int'(r.cols_1); c++) begin
            sums = '0;
            for (int n = 0; n <= int'(r.cin_1); n++) begin
                p = random_prod();
                for (int i = 0; i < `KERNEL_W_MAX; i++) begin
                    sums[i] = sums[i] + sign_extend(p[i]);
                end
                apply_beat(1'b0, (c == 0) && (n == 0) && !r.pre_cfg, r.stall, p);
            end
            exp_q.push_back(expect_column(r, c, sums));
            name_q.push_back($sformatf("%s col %0d", row_name[idx], c));
        end
    endtask

    // Outputs are sampled mid-cycle away from the rising edge
    always @(negedge aclk) begin
        if (rst_n && out_valid) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("out_valid went high with no result pending at %0t", $time);
            end else begin
                exp_val  = exp_q.pop_front();
                exp_name = name_q.pop_front();
                checks++;
                if (col_out !== exp_val) begin
                    errors++;
                    $display("Fail %s: expected %h actual %h", exp_name, exp_val, col_out);
                end
            end
        end
    end

    // Stops a run that no longer makes progress
    initial begin
        wait (table_ready);
        #(watchdog_ns);
        $display("Timeout at %0t, the stream did not finish in time", $time);
        $display("Checks %0d, errors %0d", checks, errors + 1);
        $display("Errors found");
        $finish;
    end

    initial begin
        int total_beats;
        aclk        = 1'b0;
        rst_n       = 1'b0;
        aclken      = 1'b0;
        row_start   = 1'b0;
        valid_in    = 1'b0;
        cfg_beat    = 1'b0;
        cfg         = '0;
        prod_in     = '0;
        errors      = 0;
        checks      = 0;
        table_ready = 1'b0;
        lfsr_state  = 32'h41a861e5;
        add_row(0, "kw3_basic",     3,  7, 2, 1'b0, 1'b0, 1'b0);
        add_row(1, "kw5_config",    5,  9, 1, 1'b0, 1'b0, 1'b1);
        add_row(2, "kw7_chain",     7, 11, 1, 1'b0, 1'b0, 1'b0);  // 7, 3, 5 back to back
        add_row(3, "kw3_chain",     3,  5, 0, 1'b0, 1'b0, 1'b0);
        add_row(4, "kw5_chain",     5,  8, 2, 1'b0, 1'b0, 1'b0);
        add_row(5, "pass_1x1",      1,  4, 3, 1'b1, 1'b0, 1'b0);
        add_row(6, "kw7_stall",     7, 10, 2, 1'b0, 1'b1, 1'b0);
        add_row(7, "kw3_stall_cfg", 3,  6, 1, 1'b0, 1'b1, 1'b1);
        add_row(8, "kw5_short",     5,  4, 0, 1'b0, 1'b0, 1'b1);
        total_beats = 0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            total_beats += (int'(row_table[i].cols_1) + 1) * (int'(row_table[i].cin_1) + 1);
            total_beats += int'(row_table[i].pre_cfg);
        end
        watchdog_ns = total_beats * 4.0 * 4.0;
        table_ready = 1'b1;
        repeat (3) @(posedge aclk);
        #0.5;
        rst_n  = 1'b1;
        aclken = 1'b1;
        repeat (2) @(posedge aclk);  // Idle cycles after reset
        #0.5;
        if (out_valid !== 1'b0) begin
            errors++;
            $display("out_valid is high after reset before any beat was sent");
        end
        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(i);
        end
        valid_in  = 1'b0;
        row_start = 1'b0;
        cfg_beat  = 1'b0;
        for (int w = 0; (w < 8) && (exp_q.size() != 0); w++) begin
            @(posedge aclk);
        end
        repeat (2) @(posedge aclk);  // Catch a stray pulse after the last result
        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d expected results never appeared on out_valid", exp_q.size());
        end
        $display("Checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: build.f
+incdir+.
conv_cfg_pkg.sv
lane_data_pkg.sv
register.sv
col_tracker.sv
pad_filter.sv
psum_masker.sv
pad_top.sv
tb_pad_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the padding stage testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f build.f --top-module tb_pad_top \
    -o sim_pad_top > build.log 2>&1 \
    && ./obj_dir/sim_pad_top > sim.log 2>&1 \
    || { echo "Build or simulation run failed"; cat build.log sim.log 2>/dev/null; exit 1; }

cat sim.log

grep -q "Errors found" sim.log \
    && { echo "Simulation FAILED"; exit 1; } \
    || { echo "Simulation PASSED"; exit 0; }
